// File: verif/idu_vectors.txt
# G name: new test group | A: add x1,xk,xk for k=0..31, reads checked against the model
# W rd data: write one register | R lo hi: random data into lo..hi
# D inst rs1_data rs2_data imm rd alu_op ctrl(src_imm rw mr mw br jp) illegal
G reset clears the file
A
G immediate assembly
D 12300293 00000000 00000000 00000123 5 0 110000 0   # addi x5, x0, 0x123
D fff00293 00000000 00000000 ffffffff 5 0 110000 0   # addi x5, x0, -1
D ffc12303 00000000 00000000 fffffffc 6 0 111000 0   # lw x6, -4(x2)
D 0071a423 00000000 00000000 00000008 8 0 100100 0   # sw x7, 8(x3)
D fe71ac23 00000000 00000000 fffffff8 24 0 100100 0  # sw x7, -8(x3)
D 00208863 00000000 00000000 00000010 16 1 000010 0  # beq x1, x2, +16
D fe209ee3 00000000 00000000 fffffffc 29 1 000010 0  # bne x1, x2, -4
D 12345437 00000000 00000000 12345000 8 10 110000 0  # lui x8, 0x12345
D 80000497 00000000 00000000 80000000 9 0 110000 0   # auipc x9, 0x80000
D 001000ef 00000000 00000000 00000800 1 0 110001 0   # jal x1, +2048
D fffff0ef 00000000 00000000 fffffffe 1 0 110001 0   # jal x1, -2
D 00c280e7 00000000 00000000 0000000c 1 0 110001 0   # jalr x1, 12(x5)
G control decoding
D 402081b3 00000000 00000000 00000000 3 1 010000 0   # sub x3, x1, x2
D 002091b3 00000000 00000000 00000000 3 2 010000 0   # sll
D 0020a1b3 00000000 00000000 00000000 3 3 010000 0   # slt
D 0020b1b3 00000000 00000000 00000000 3 4 010000 0   # sltu
D 0020c1b3 00000000 00000000 00000000 3 5 010000 0   # xor
D 0020d1b3 00000000 00000000 00000000 3 6 010000 0   # srl
D 4020d1b3 00000000 00000000 00000000 3 7 010000 0   # sra
D 0020e1b3 00000000 00000000 00000000 3 8 010000 0   # or
D 0020f1b3 00000000 00000000 00000000 3 9 010000 0   # and
D 0050a193 00000000 00000000 00000005 3 3 110000 0   # slti x3, x1, 5
D 4040d193 00000000 00000000 00000404 3 7 110000 0   # srai x3, x1, 4
D ff00f193 00000000 00000000 fffffff0 3 9 110000 0   # andi x3, x1, -16
G illegal detection
D 00000073 00000000 00000000 00000000 0 0 000000 1   # ecall, unknown opcode
D 022081b3 00000000 00000000 00000000 3 0 000000 1   # mul, bad funct7
D 00208833 00000000 00000000 00000000 16 0 000000 1  # add x16, x1, x2
D 0008a183 00000000 00000000 00000000 3 0 100000 1   # lw x3, 0(x17)
D 00000000 00000000 00000000 00000000 0 0 000000 1   # all-zero word
G write then read
R 1 15
A
W 0 deadbeef
W 16 12345678
W 31 cafef00d
A
W 5 a5a5a5a5
D 00028133 a5a5a5a5 00000000 00000000 2 0 010000 0   # add x2, x5, x0

// File: idu.f
design/idu_pkg.sv
design/gpr_file.sv
design/inst_decoder.sv
design/imm_gen.sv
design/idu_top.sv
verif/idu_tb.sv

// File: Bender.yml
package:
  name: idu

sources:
  - design/idu_pkg.sv
  - design/gpr_file.sv
  - design/inst_decoder.sv
  - design/imm_gen.sv
  - design/idu_top.sv
  - target: simulation
    files:
      - verif/idu_tb.sv

// File: verif/idu_tb.sv
`timescale 1ns/1ps

module idu_tb;

    localparam int    reset_cycles = 10;
    localparam string vec_path     = "verif/idu_vectors.txt";

    logic                           clk;
    logic                           rst;
    logic [idu_pkg::xlen-1:0]       inst;
    logic                           wb_en;
    logic [idu_pkg::reg_addr_w-1:0] wb_rd;
    logic [idu_pkg::xlen-1:0]       wb_data;
    logic [idu_pkg::xlen-1:0]       rs1_data;
    logic [idu_pkg::xlen-1:0]       rs2_data;
    logic [idu_pkg::xlen-1:0]       imm;
    logic [idu_pkg::reg_addr_w-1:0] rd;
    idu_pkg::alu_op_t               alu_op;
    logic                           alu_src_imm;
    logic                           reg_write;
    logic                           mem_read;
    logic                           mem_write;
    logic                           branch;
    logic                           jump;
    logic                           illegal;

    logic [31:0] model [idu_pkg::nr_gpr];  // expected register contents
    int          cycles = 0;
    int          limit  = reset_cycles + 50;
    int          group_errs;
    int          n_pass;
    int          n_fail;
    int          setup_errs;

    idu_top dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // x0 and the missing x16..x31 read zero
    function automatic logic [31:0] model_read(input logic [4:0] idx);
        if (idx == 0 || idx >= idu_pkg::nr_gpr) begin
            return '0;
        end
        return model[idx[3:0]];
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp_v, act_v);
            group_errs++;
        end
    endtask

    task automatic write_reg(input int idx, input logic [31:0] data);
        wb_en   = 1'b1;
        wb_rd   = idx[4:0];
        wb_data = data;
        @(negedge clk);
        wb_en = 1'b0;
        if (idx > 0 && idx < idu_pkg::nr_gpr) begin
            model[idx] = data;
        end
    endtask

    task automatic apply(input logic [31:0] word);
        inst = word;
        @(negedge clk);  // sampled a full cycle later
    endtask

    task automatic check_reads();
        check_val("rs1_data", model_read(inst[19:15]), rs1_data);
        check_val("rs2_data", model_read(inst[24:20]), rs2_data);
    endtask

    task automatic end_group(input string name);
        if (group_errs == 0) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: fail with %0d mismatches", name, group_errs);
        end
        group_errs = 0;
    endtask

    initial begin
        int          fd;
        int          steps;
        int          lo;
        int          hi;
        int          k;
        int          idx;
        int          e_rd;
        int          e_alu;
        bit          in_group;
        string       line;
        string       gname;
        string       lines[$];
        logic [31:0] word;
        logic [31:0] e_rs1;
        logic [31:0] e_rs2;
        logic [31:0] e_imm;
        logic [5:0]  e_ctl;
        logic        e_ill;

        clk        = 1'b0;
        rst        = 1'b1;
        inst       = '0;
        wb_en      = 1'b0;
        wb_rd      = '0;
        wb_data    = '0;
        group_errs = 0;
        n_pass     = 0;
        n_fail     = 0;
        setup_errs = 0;
        steps      = 0;
        in_group   = 1'b0;
        void'($urandom(32'h3f4e3993));
        foreach (model[j]) begin
            model[j] = '0;  // file is cleared by reset
        end

        fd = $fopen(vec_path, "r");
        if (fd == 0) begin
            $display("vector file %s could not be opened", vec_path);
            setup_errs++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                while (line.len() > 0 && (line.getc(line.len() - 1) == "\n" ||
                       line.getc(line.len() - 1) == "\r")) begin
                    line = line.substr(0, line.len() - 2);
                end
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;
                end
                lines.push_back(line);
                if (line.getc(0) == "R") begin
                    void'($sscanf(line, "R %d %d", lo, hi));
                    steps += hi - lo + 1;
                end else if (line.getc(0) == "A") begin
                    steps += 32;
                end else if (line.getc(0) != "G") begin
                    steps++;
                end
            end
            $fclose(fd);
        end
        limit = 2 * steps + reset_cycles + 50;

        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;

        foreach (lines[i]) begin
            line = lines[i];
            case (line.getc(0))
                "G": begin
                    if (in_group) begin
                        end_group(gname);
                    end
                    gname    = line.substr(2, line.len() - 1);
                    in_group = 1'b1;
                end
                "W": begin
                    void'($sscanf(line, "W %d %h", idx, word));
                    write_reg(idx, word);
                end
                "R": begin
                    void'($sscanf(line, "R %d %d", lo, hi));
                    for (k = lo; k <= hi; k++) begin
                        write_reg(k, $urandom());
                    end
                end
                "A": begin  // add x1, xk, xk for every index
                    for (k = 0; k < 32; k++) begin
                        apply({7'b0, 5'(k), 5'(k), 3'b000, 5'd1, idu_pkg::opc_op});
                        check_reads();
                    end
                end
                "D": begin
                    void'($sscanf(line, "D %h %h %h %h %d %d %b %b", word, e_rs1, e_rs2,
                                  e_imm, e_rd, e_alu, e_ctl, e_ill));
                    apply(word);
                    check_val("rs1_data", e_rs1, rs1_data);
                    check_val("rs2_data", e_rs2, rs2_data);
                    check_val("imm", e_imm, imm);
                    check_val("rd", e_rd, rd);
                    check_val("alu_op", e_alu, alu_op);
                    check_val("controls", e_ctl,
                              {alu_src_imm, reg_write, mem_read, mem_write, branch, jump});
                    check_val("illegal", e_ill, illegal);
                end
                default: begin
                    $display("vector line not understood: %s", line);
                    setup_errs++;
                end
            endcase
        end
        if (in_group) begin
            end_group(gname);
        end

        $display("%0d tests passed, %0d tests failed, %0d setup errors",
                 n_pass, n_fail, setup_errs);
        if (n_pass > 0 && n_fail == 0 && setup_errs == 0 && group_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: design/idu_top.sv
`timescale 1ns/1ps

module idu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [idu_pkg::xlen-1:0]       inst,
    input  logic                           wb_en,
    input  logic [idu_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [idu_pkg::xlen-1:0]       wb_data,
    output logic [idu_pkg::xlen-1:0]       rs1_data,
    output logic [idu_pkg::xlen-1:0]       rs2_data,
    output logic [idu_pkg::xlen-1:0]       imm,
    output logic [idu_pkg::reg_addr_w-1:0] rd,
    output idu_pkg::alu_op_t               alu_op,
    output logic                           alu_src_imm,
    output logic                           reg_write,
    output logic                           mem_read,
    output logic                           mem_write,
    output logic                           branch,
    output logic                           jump,
    output logic                           illegal
);

    idu_pkg::imm_fmt_t imm_fmt;  // decoder to immediate generator

    assign rd = inst[11:7];

    inst_decoder u_decoder (
        .inst        (inst),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .reg_write   (reg_write),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .branch      (branch),
        .jump        (jump),
        .imm_fmt     (imm_fmt),
        .illegal     (illegal)
    );

    imm_gen u_imm_gen (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    // fields are read even for formats without rs2, execute ignores them
    gpr_file u_gpr (
        .clk      (clk),
        .rst      (rst),
        .rs1      (inst[19:15]),
        .rs2      (inst[24:20]),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

// File: design/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  logic [idu_pkg::xlen-1:0] inst,
    input  idu_pkg::imm_fmt_t        imm_fmt,
    output logic [idu_pkg::xlen-1:0] imm
);

    logic sign;

    assign sign = inst[idu_pkg::xlen-1];  // every format extends from bit 31

    always_comb begin
        case (imm_fmt)
            idu_pkg::imm_i: begin
                imm = {{(idu_pkg::xlen-12){sign}}, inst[31:20]};
            end
            idu_pkg::imm_s: begin
                imm = {{(idu_pkg::xlen-12){sign}}, inst[31:25], inst[11:7]};
            end
            idu_pkg::imm_b: begin  // offset in half words
                imm = {{(idu_pkg::xlen-13){sign}}, sign, inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            idu_pkg::imm_u: begin
                imm = {inst[31:12], 12'h000};
            end
            idu_pkg::imm_j: begin
                imm = {{(idu_pkg::xlen-21){sign}}, sign, inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: imm = '0;  // imm_none
        endcase
    end

    // X here would silently poison the operand mux downstream
    a_fmt_known: assert final (!$isunknown(imm_fmt))
        else $error("imm_gen: immediate format is unknown");

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [idu_pkg::xlen-1:0] inst,
    output idu_pkg::alu_op_t         alu_op,
    output logic                     alu_src_imm,
    output logic                     reg_write,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic                     branch,
    output logic                     jump,
    output idu_pkg::imm_fmt_t        imm_fmt,
    output logic                     illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;   // 0100000 selects sub / sra
    logic       rw_raw;
    logic       mr_raw;
    logic       mw_raw;
    logic       br_raw;
    logic       jp_raw;
    logic       bad_enc;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;
    logic       bad_reg;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    always_comb begin
        alu_op      = idu_pkg::alu_add;
        alu_src_imm = 1'b0;
        imm_fmt     = idu_pkg::imm_none;
        rw_raw      = 1'b0;
        mr_raw      = 1'b0;
        mw_raw      = 1'b0;
        br_raw      = 1'b0;
        jp_raw      = 1'b0;
        bad_enc     = 1'b0;
        use_rd      = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        case (opcode)
            idu_pkg::opc_lui: begin
                alu_op      = idu_pkg::alu_pass_b;
                alu_src_imm = 1'b1;
                imm_fmt     = idu_pkg::imm_u;
                rw_raw      = 1'b1;
                use_rd      = 1'b1;
            end
            idu_pkg::opc_auipc: begin  // operand a is the pc
                alu_src_imm = 1'b1;
                imm_fmt     = idu_pkg::imm_u;
                rw_raw      = 1'b1;
                use_rd      = 1'b1;
            end
            idu_pkg::opc_jal: begin
                alu_src_imm = 1'b1;
                imm_fmt     = idu_pkg::imm_j;
                rw_raw      = 1'b1;
                jp_raw      = 1'b1;
                use_rd      = 1'b1;
            end
            idu_pkg::opc_jalr: begin
                alu_src_imm = 1'b1;
                imm_fmt     = idu_pkg::imm_i;
                rw_raw      = 1'b1;
                jp_raw      = 1'b1;
                use_rd      = 1'b1;
                use_rs1     = 1'b1;
                bad_enc     = (funct3 != 3'b000);
            end
            idu_pkg::opc_branch: begin
                alu_op  = idu_pkg::alu_sub;   // compare rs1 against rs2
                imm_fmt = idu_pkg::imm_b;
                br_raw  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                bad_enc = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            idu_pkg::opc_load: begin
                alu_src_imm = 1'b1;
                imm_fmt     = idu_pkg::imm_i;
                rw_raw      = 1'b1;
                mr_raw      = 1'b1;
                use_rd      = 1'b1;
                use_rs1     = 1'b1;
                bad_enc     = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);  // lb..lhu only
            end
            idu_pkg::opc_store: begin
                alu_src_imm = 1'b1;
                imm_fmt     = idu_pkg::imm_s;
                mw_raw      = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                bad_enc     = (funct3[2] || funct3 == 3'b011);  // sb, sh, sw
            end
            idu_pkg::opc_op_imm, idu_pkg::opc_op: begin
                alu_src_imm = (opcode == idu_pkg::opc_op_imm);
                imm_fmt     = alu_src_imm ? idu_pkg::imm_i : idu_pkg::imm_none;
                rw_raw      = 1'b1;
                use_rd      = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = !alu_src_imm;  // shamt sits in the rs2 slot otherwise
                case (funct3)
                    3'b000: begin
                        alu_op  = (!alu_src_imm && f7_alt) ? idu_pkg::alu_sub : idu_pkg::alu_add;
                        bad_enc = !alu_src_imm && !(f7_zero || f7_alt);
                    end
                    3'b001: begin
                        alu_op  = idu_pkg::alu_sll;
                        bad_enc = !f7_zero;
                    end
                    3'b101: begin
                        alu_op  = f7_alt ? idu_pkg::alu_sra : idu_pkg::alu_srl;
                        bad_enc = !(f7_zero || f7_alt);
                    end
                    3'b010:  alu_op = idu_pkg::alu_slt;
                    3'b011:  alu_op = idu_pkg::alu_sltu;
                    3'b100:  alu_op = idu_pkg::alu_xor;
                    3'b110:  alu_op = idu_pkg::alu_or;
                    default: alu_op = idu_pkg::alu_and;
                endcase
                // funct7 is free for the immediate forms except shifts
                if (!alu_src_imm && funct3 != 3'b000 && funct3 != 3'b101) begin
                    bad_enc = !f7_zero;
                end
            end
            default: bad_enc = 1'b1;  // csr, fence, system, zero word
        endcase
    end

    // x16..x31 do not exist in RV32E
    assign bad_reg = (use_rd  && inst[11])
                  || (use_rs1 && inst[19])
                  || (use_rs2 && inst[24]);
    assign illegal = bad_enc || bad_reg;

    assign reg_write = rw_raw && !illegal;
    assign mem_read  = mr_raw && !illegal;
    assign mem_write = mw_raw && !illegal;
    assign branch    = br_raw && !illegal;
    assign jump      = jp_raw && !illegal;

    a_illegal_quiet: assert final (!(illegal && (reg_write || mem_write || mem_read)))
        else $error("inst_decoder: side effect enabled on illegal inst %h", inst);

endmodule

// File: design/gpr_file.sv
`timescale 1ns/1ps

module gpr_file (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [idu_pkg::reg_addr_w-1:0] rs1,
    input  logic [idu_pkg::reg_addr_w-1:0] rs2,
    input  logic                           wb_en,
    input  logic [idu_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [idu_pkg::xlen-1:0]       wb_data,
    output logic [idu_pkg::xlen-1:0]       rs1_data,
    output logic [idu_pkg::xlen-1:0]       rs2_data
);

    logic [idu_pkg::xlen-1:0]   regs [idu_pkg::nr_gpr];
    logic [idu_pkg::nr_gpr-1:0] hit1;  // one-hot read selects
    logic [idu_pkg::nr_gpr-1:0] hit2;
    logic [idu_pkg::nr_gpr-1:1] we;    // per-register write strobes

    // indices 16..31 match no entry, so they read zero and never write
    for (genvar j = 0; j < idu_pkg::nr_gpr; j++) begin : g_entry
        assign hit1[j] = (rs1 == idu_pkg::reg_addr_w'(j));
        assign hit2[j] = (rs2 == idu_pkg::reg_addr_w'(j));
        if (j != 0) begin : g_rw  // x0 is hardwired and has no strobe
            assign we[j] = wb_en && (wb_rd == idu_pkg::reg_addr_w'(j));
        end

        // only the addressed entry may move on a write
        a_only_target: assert property (@(posedge clk) disable iff (rst)
            !(wb_en && wb_rd == idu_pkg::reg_addr_w'(j)) |=> $stable(regs[j]))
            else $error("gpr_file: x%0d changed without being addressed", j);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < idu_pkg::nr_gpr; k++) begin
                regs[k] <= '0;
            end
        end else begin
            for (int k = 1; k < idu_pkg::nr_gpr; k++) begin
                if (we[k]) regs[k] <= wb_data;
            end
        end
    end

    // and-or mux without write bypass
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        for (int k = 0; k < idu_pkg::nr_gpr; k++) begin
            rs1_data = rs1_data | ({idu_pkg::xlen{hit1[k]}} & regs[k]);
            rs2_data = rs2_data | ({idu_pkg::xlen{hit2[k]}} & regs[k]);
        end
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("gpr_file: x0 holds a nonzero value");

endmodule

// File: design/idu_pkg.sv
package idu_pkg;

    // datapath and register file geometry
    localparam int xlen       = 32;
    localparam int nr_gpr     = 16;  // RV32E keeps x0..x15
    localparam int reg_addr_w = 5;   // register fields stay 5 bits wide in the encoding

    // RV32 major opcodes in inst[6:0]
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // operation requested from the execute stage
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10   // operand b straight through, used by lui
    } alu_op_t;

    // immediate layouts of the base ISA
    typedef enum logic [2:0] {
        imm_none = 3'd0,
        imm_i    = 3'd1,
        imm_s    = 3'd2,
        imm_b    = 3'd3,
        imm_u    = 3'd4,
        imm_j    = 3'd5
    } imm_fmt_t;

endpackage
